// ==== packet_capture.f ====
+incdir+testbench
source/packet_capture_pkg.sv
source/packet_ram.sv
source/packet_writer.sv
source/capture_fsm.sv
source/capture_regs.sv
source/packet_capture.sv
testbench/packet_capture_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the packet capture testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module packet_capture_tb \
    -f packet_capture.f -o packet_capture_sim

# The simulation exits non-zero on failure, the log decides the result
./obj_dir/packet_capture_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1

// ==== testbench/packet_capture_tb_tasks.svh ====
// Packet capture testbench tasks

task automatic check(input string what, input word_t actual, input word_t expected);
    if (actual !== expected) begin
        $display("ERR %0t: %s, got %h expected %h", $time, what, actual, expected);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at first mismatch");
    end
endtask

// --------------------------------------------------
// Register bus access
// --------------------------------------------------
task automatic reg_write(input reg_addr_t addr, input word_t data);
    @(negedge clk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
endtask

task automatic reg_read(input reg_addr_t addr, output word_t data);
    int lat;
    @(negedge clk);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_rd = 1'b0;
    lat    = 1;
    while (!reg_rvalid) begin
        @(negedge clk);
        lat++;
    end
    check("read latency", word_t'(lat), 32'd2);
    data = reg_rdata;
endtask

task automatic poll_status_code(input status_code_t code, output word_t st);
    do begin
        reg_read(REG_STATUS, st);
    end while (st[1:0] !== code);
endtask

// Until done or error shows up
task automatic poll_status_flags(output word_t st);
    do begin
        reg_read(REG_STATUS, st);
    end while (st[5:4] == 2'b00);
endtask

// --------------------------------------------------
// Packet generation and reference model
// --------------------------------------------------
task automatic build_packet(input int len, input bit captured);
    int    nwords;
    int    vb;
    word_t data;
    meta_t m;
    nwords = (len + 3) / 4;
    m      = meta_t'($urandom);
    for (int w = 0; w < nwords; w++) begin
        data = $urandom;
        vb   = (len - 4 * w >= 4) ? 4 : len - 4 * w;
        src_data.push_back(data);
        src_ctl.push_back({(vb == 4) ? 2'd0 : 2'(vb), w == nwords - 1, w == 0});
        src_meta.push_back(m);
        // First byte in 31:24 and unused tail bytes read back as zero
        if (captured && w < MEM_DEPTH) begin
            mem_model[w] = data & (32'hFFFF_FFFF << (8 * (4 - vb)));
        end
    end
    if (captured) begin
        exp_bytes = size_t'((len > MEM_BYTES) ? MEM_BYTES : len);
        exp_meta  = m;
    end
endtask

task automatic wait_source_idle();
    while (src_data.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
endtask

task automatic check_window();
    word_t v;
    for (int n = 0; n < MEM_DEPTH; n++) begin
        reg_read(DATA_BASE + reg_addr_t'(4 * n), v);
        check($sformatf("data word %0d", n), v, mem_model[n]);
    end
endtask

task automatic check_capture(input bit overflow);
    word_t st;
    word_t v;
    poll_status_flags(st);
    check("status code", word_t'(st[1:0]), word_t'(STATUS_CODE_READY));
    check("done flag", word_t'(st[4]), word_t'(!overflow));
    check("error flag", word_t'(st[5]), word_t'(overflow));
    check("packet bytes", word_t'(st[31:16]), word_t'(exp_bytes));
    reg_read(REG_META, v);
    check("meta", v, word_t'(exp_meta));
    check_window();
endtask

// --------------------------------------------------
// Scenarios
// --------------------------------------------------
task automatic reset_scenario();
    word_t st;
    word_t v;
    reg_read(REG_STATUS, st);
    check("code after reset", word_t'(st[1:0]), word_t'(STATUS_CODE_RESET));
    poll_status_code(STATUS_CODE_DISABLED, st);
    check("flags after reset", word_t'(st[5:4]), '0);
    reg_read(REG_INFO, v);
    check("info", v, {8'h00, 8'd16, 16'(MEM_BYTES)});
    check("en before enable", word_t'(en), '0);
    check_window();
    reg_write(REG_CONTROL, 32'd1);
    check("en after enable", word_t'(en), 32'd1);
    poll_status_code(STATUS_CODE_READY, st);
endtask

task automatic capture_scenario(input int len);
    word_t st;
    reg_write(REG_COMMAND, word_t'(COMMAND_CODE_CAPTURE));
    poll_status_code(STATUS_CODE_BUSY, st);
    build_packet(len, 1'b1);
    check_capture(len > MEM_BYTES);
    wait_source_idle();
endtask

task automatic ignored_packet_scenario();
    word_t st;
    word_t v;
    reg_write(REG_CONTROL, 32'd0);
    poll_status_code(STATUS_CODE_DISABLED, st);
    check("en while disabled", word_t'(en), '0);
    build_packet(1 + int'($urandom % MEM_BYTES), 1'b0);
    wait_source_idle();
    // Enabled but no command issued yet
    reg_write(REG_CONTROL, 32'd1);
    poll_status_code(STATUS_CODE_READY, st);
    build_packet(1 + int'($urandom % MEM_BYTES), 1'b0);
    wait_source_idle();
    reg_read(REG_STATUS, st);
    check("bytes kept", word_t'(st[31:16]), word_t'(exp_bytes));
    reg_read(REG_META, v);
    check("meta kept", v, word_t'(exp_meta));
    check_window();
endtask

task automatic nop_scenario();
    word_t st;
    reg_write(REG_COMMAND, word_t'(COMMAND_CODE_NOP));
    poll_status_flags(st);
    check("nop done", word_t'(st[4]), 32'd1);
    check("nop error", word_t'(st[5]), '0);
    check("nop code", word_t'(st[1:0]), word_t'(STATUS_CODE_READY));
    check("nop bytes", word_t'(st[31:16]), word_t'(exp_bytes));
    reg_read(REG_STATUS, st);
    check("flags after read", word_t'(st[5:4]), '0);
    check_window();
endtask

task automatic credit_scenario();
    wait_source_idle();
    check("stalls without credit", word_t'(stall_cnt), '0);
    check("credits returned", word_t'(credits_returned), word_t'(words_sent + CREDITS));
endtask

// ==== testbench/packet_capture_tb.sv ====
// Packet capture testbench
`timescale 1ns/1ns

module packet_capture_tb import packet_capture_pkg::*; ();

    localparam int MEM_DEPTH = 64;
    localparam int CREDITS   = 4;
    localparam int MEM_BYTES = MEM_DEPTH * 4;
    localparam int unsigned SEED = 32'h3d3;
    // Well above the length of all scenarios together
    localparam int TIMEOUT_CYCLES = 20000;

    logic       clk;
    logic       srst;
    logic       pkt_valid = 1'b0;
    logic       pkt_sop   = 1'b0;
    logic       pkt_eop   = 1'b0;
    word_t      pkt_data  = '0;
    logic [1:0] pkt_bytes = 2'd0;
    meta_t      pkt_meta  = '0;
    logic       pkt_credit;
    logic       reg_wr;
    logic       reg_rd;
    reg_addr_t  reg_addr;
    word_t      reg_wdata;
    word_t      reg_rdata;
    logic       reg_rvalid;
    logic       en;

    // Source queues with control as {bytes, eop, sop}
    word_t       src_data[$];
    logic [3:0]  src_ctl[$];
    meta_t       src_meta[$];
    logic [3:0]  cur_ctl;
    int          credit_cnt       = 0;
    int          credits_returned = 0;
    int          words_sent       = 0;
    int          stall_cnt        = 0;
    int          gap_cnt          = 0;
    int          cycle_cnt        = 0;
    int unsigned seed_val;

    // Reference image of the capture RAM
    word_t mem_model[MEM_DEPTH];
    size_t exp_bytes;
    meta_t exp_meta;

    packet_capture #(.MEM_DEPTH(MEM_DEPTH), .CREDITS(CREDITS)) dut (
        .clk, .srst,
        .pkt_valid, .pkt_sop, .pkt_eop, .pkt_data, .pkt_bytes, .pkt_meta, .pkt_credit,
        .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_rvalid,
        .en
    );

    `include "packet_capture_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "Timeout");
        end
    end

    // --------------------------------------------------
    // Credit-obeying packet source
    // --------------------------------------------------
    always @(negedge clk) begin
        if (srst) begin
            credit_cnt       = 0;
            credits_returned = 0;
            gap_cnt          = 0;
            pkt_valid        = 1'b0;
        end else begin
            if (pkt_credit) begin
                credit_cnt++;
                credits_returned++;
            end
            pkt_valid = 1'b0;
            pkt_sop   = 1'b0;
            pkt_eop   = 1'b0;
            if (gap_cnt > 0) begin
                gap_cnt--;
            end else if (src_data.size() != 0) begin
                if (credit_cnt > 0) begin
                    cur_ctl   = src_ctl.pop_front();
                    pkt_data  = src_data.pop_front();
                    pkt_meta  = src_meta.pop_front();
                    pkt_valid = 1'b1;
                    pkt_sop   = cur_ctl[0];
                    pkt_eop   = cur_ctl[1];
                    pkt_bytes = cur_ctl[3:2];
                    credit_cnt--;
                    words_sent++;
                    if ($urandom % 4 == 0) gap_cnt = 1 + int'($urandom % 3);
                end else if (credits_returned >= CREDITS) begin
                    // Word ready but no credit left after the grant
                    stall_cnt++;
                end
            end
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        seed_val  = $urandom(SEED);
        srst      = 1'b1;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        exp_bytes = '0;
        exp_meta  = '0;
        for (int n = 0; n < MEM_DEPTH; n++) mem_model[n] = '0;
        repeat (8) @(negedge clk);
        srst = 1'b0;

        reset_scenario();
        capture_scenario(1 + int'($urandom % MEM_BYTES));
        ignored_packet_scenario();
        capture_scenario(1 + int'($urandom % MEM_BYTES));
        capture_scenario(1 + int'($urandom % MEM_BYTES));
        // Longer than the RAM
        capture_scenario(MEM_BYTES + 1 + int'($urandom % 60));
        nop_scenario();
        credit_scenario();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== source/packet_capture.sv ====
// Packet capture subsystem
`timescale 1ns/1ns

module packet_capture import packet_capture_pkg::*; #(
    parameter int MEM_DEPTH = 64,
    parameter int CREDITS   = 4
) (
    input  logic       clk,
    input  logic       srst,
    input  logic       pkt_valid,
    input  logic       pkt_sop,
    input  logic       pkt_eop,
    input  word_t      pkt_data,
    input  logic [1:0] pkt_bytes,
    input  meta_t      pkt_meta,
    output logic       pkt_credit,
    input  logic       reg_wr,
    input  logic       reg_rd,
    input  reg_addr_t  reg_addr,
    input  word_t      reg_wdata,
    output word_t      reg_rdata,
    output logic       reg_rvalid,
    output logic       en
);

    localparam int ADDR_WID = $clog2(MEM_DEPTH);

    logic                enable;
    logic                command_wr;
    command_code_t       command_code;
    logic                status_rd;
    status_code_t        status_code;
    logic                status_done;
    logic                status_error;
    size_t               packet_bytes;
    meta_t               meta;

    logic                arm;
    logic                pkt_done;
    size_t               pkt_size;
    meta_t               pkt_meta_out;
    logic                pkt_overflow;

    logic                rd_en;
    logic [ADDR_WID-1:0] rd_addr;
    word_t               rd_data;
    logic                wr_en;
    logic [ADDR_WID-1:0] wr_addr;
    word_t               wr_data;
    logic                init_done;

    // Enable exported for downstream logic
    assign en = enable;

    // --------------------------------------------------
    // Control plane
    // --------------------------------------------------
    capture_regs #(.MEM_DEPTH(MEM_DEPTH)) i_capture_regs (
        .clk, .srst,
        .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_rvalid,
        .enable, .command_wr, .command_code, .status_rd,
        .status_code, .status_done, .status_error, .packet_bytes, .meta,
        .rd_en, .rd_addr, .rd_data
    );

    capture_fsm i_capture_fsm (
        .clk, .srst, .init_done,
        .enable, .command_wr, .command_code, .status_rd,
        .pkt_done, .pkt_size, .pkt_meta_out, .pkt_overflow,
        .arm, .status_code, .status_done, .status_error, .packet_bytes, .meta
    );

    // --------------------------------------------------
    // Data plane
    // --------------------------------------------------
    packet_writer #(.MEM_DEPTH(MEM_DEPTH), .CREDITS(CREDITS)) i_packet_writer (
        .clk, .srst,
        .pkt_valid, .pkt_data, .pkt_sop, .pkt_eop, .pkt_bytes, .pkt_meta, .pkt_credit,
        .arm, .pkt_done, .pkt_size, .pkt_meta_out, .pkt_overflow,
        .wr_en, .wr_addr, .wr_data
    );

    packet_ram #(.MEM_DEPTH(MEM_DEPTH)) i_packet_ram (
        .clk, .srst,
        .wr_en, .wr_addr, .wr_data,
        .rd_en, .rd_addr, .rd_data,
        .init_done
    );

endmodule

// ==== source/capture_regs.sv ====
// Capture register block
`timescale 1ns/1ns

module capture_regs import packet_capture_pkg::*; #(
    parameter int MEM_DEPTH = 64,
    localparam int ADDR_WID = $clog2(MEM_DEPTH)
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                reg_wr,
    input  logic                reg_rd,
    input  reg_addr_t           reg_addr,
    input  word_t               reg_wdata,
    output word_t               reg_rdata,
    output logic                reg_rvalid,
    output logic                enable,
    output logic                command_wr,
    output command_code_t       command_code,
    output logic                status_rd,
    input  status_code_t        status_code,
    input  logic                status_done,
    input  logic                status_error,
    input  size_t               packet_bytes,
    input  meta_t               meta,
    output logic                rd_en,
    output logic [ADDR_WID-1:0] rd_addr,
    input  word_t               rd_data
);

    localparam int MEM_BYTES = MEM_DEPTH * 4;

    command_code_t last_code;
    reg_addr_t     win_offset;
    logic          in_window;
    word_t         reg_value;

    logic          rd_pending;
    logic          rd_window;
    word_t         reg_value_q;

    // --------------------------------------------------
    // Write decode
    // --------------------------------------------------
    assign command_wr   = reg_wr && (reg_addr == REG_COMMAND);
    assign command_code = command_code_t'(reg_wdata[0]);

    always_ff @(posedge clk) begin
        if (srst) begin
            enable    <= 1'b0;
            last_code <= COMMAND_CODE_NOP;
        end else if (reg_wr) begin
            if (reg_addr == REG_CONTROL) begin
                enable <= reg_wdata[0];
            end
            if (reg_addr == REG_COMMAND) begin
                last_code <= command_code;
            end
        end
    end

    // --------------------------------------------------
    // Read decode
    // --------------------------------------------------
    assign status_rd  = reg_rd && (reg_addr == REG_STATUS);
    assign in_window  = (reg_addr >= DATA_BASE);
    assign win_offset = reg_addr - DATA_BASE;

    // Data window goes to the RAM read port
    assign rd_en   = reg_rd && in_window;
    assign rd_addr = win_offset[ADDR_WID+1:2];

    always_comb begin
        case (reg_addr)
            REG_CONTROL: reg_value = word_t'(enable);
            REG_COMMAND: reg_value = word_t'(last_code);
            REG_STATUS: begin
                reg_value = {packet_bytes, 10'h0, status_error, status_done,
                             2'b00, status_code};
            end
            REG_INFO:    reg_value = {8'h00, 8'(META_WID), 16'(MEM_BYTES)};
            REG_META:    reg_value = word_t'(meta);
            default:     reg_value = '0;
        endcase
    end

    // Stage one matches the RAM read latency
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_pending <= 1'b0;
            rd_window  <= 1'b0;
        end else begin
            rd_pending <= reg_rd;
            rd_window  <= reg_rd && in_window;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_value_q <= reg_value;
        end
    end

    // Stage two is the output register
    always_ff @(posedge clk) begin
        if (srst) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= rd_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pending) begin
            reg_rdata <= rd_window ? rd_data : reg_value_q;
        end
    end

endmodule

// ==== source/capture_fsm.sv ====
// Capture sequencer
`timescale 1ns/1ns

module capture_fsm import packet_capture_pkg::*; (
    input  logic          clk,
    input  logic          srst,
    input  logic          init_done,
    input  logic          enable,
    input  logic          command_wr,
    input  command_code_t command_code,
    input  logic          status_rd,
    input  logic          pkt_done,
    input  size_t         pkt_size,
    input  meta_t         pkt_meta_out,
    input  logic          pkt_overflow,
    output logic          arm,
    output status_code_t  status_code,
    output logic          status_done,
    output logic          status_error,
    output size_t         packet_bytes,
    output meta_t         meta
);

    capture_state_t state;
    capture_state_t nxt_state;

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            RESET: begin
                if (init_done) nxt_state = DISABLED;
            end
            DISABLED: begin
                if (enable) nxt_state = READY;
            end
            READY: begin
                if (!enable) begin
                    nxt_state = DISABLED;
                end else if (command_wr) begin
                    nxt_state = (command_code == COMMAND_CODE_CAPTURE) ? CAPTURE : DONE;
                end
            end
            CAPTURE: begin
                if (pkt_done) nxt_state = pkt_overflow ? ERROR : DONE;
            end
            DONE, ERROR: nxt_state = READY;
            default:     nxt_state = RESET;
        endcase
    end

    assign arm = (state == CAPTURE);

    // --------------------------------------------------
    // Sticky flags where set wins over clear
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            status_done  <= 1'b0;
            status_error <= 1'b0;
        end else begin
            if (state == DONE) begin
                status_done <= 1'b1;
            end else if (command_wr || status_rd) begin
                status_done <= 1'b0;
            end
            if (state == ERROR) begin
                status_error <= 1'b1;
            end else if (command_wr || status_rd) begin
                status_error <= 1'b0;
            end
        end
    end

    // Size and metadata of the last capture
    always_ff @(posedge clk) begin
        if (srst) begin
            packet_bytes <= '0;
            meta         <= '0;
        end else if (pkt_done && state == CAPTURE) begin
            packet_bytes <= pkt_size;
            meta         <= pkt_meta_out;
        end
    end

    // Status code trails the state by one cycle
    always_ff @(posedge clk) begin
        if (srst) begin
            status_code <= STATUS_CODE_RESET;
        end else begin
            case (state)
                RESET:    status_code <= STATUS_CODE_RESET;
                DISABLED: status_code <= STATUS_CODE_DISABLED;
                CAPTURE:  status_code <= STATUS_CODE_BUSY;
                default:  status_code <= STATUS_CODE_READY;
            endcase
        end
    end

endmodule

// ==== source/packet_writer.sv ====
// Credit-based packet receiver
`timescale 1ns/1ns

module packet_writer import packet_capture_pkg::*; #(
    parameter int MEM_DEPTH = 64,
    parameter int CREDITS   = 4,
    localparam int ADDR_WID = $clog2(MEM_DEPTH)
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                pkt_valid,
    input  word_t               pkt_data,
    input  logic                pkt_sop,
    input  logic                pkt_eop,
    input  logic [1:0]          pkt_bytes,
    input  meta_t               pkt_meta,
    output logic                pkt_credit,
    input  logic                arm,
    output logic                pkt_done,
    output size_t               pkt_size,
    output meta_t               pkt_meta_out,
    output logic                pkt_overflow,
    output logic                wr_en,
    output logic [ADDR_WID-1:0] wr_addr,
    output word_t               wr_data
);

    localparam int OWED_WID = $clog2(CREDITS + 1) + 1;

    logic [OWED_WID-1:0] owed;
    logic [OWED_WID-1:0] owed_eff;
    logic                send;

    logic                active;
    logic                held;
    logic                full;
    logic                overflow;
    logic [ADDR_WID-1:0] word_idx;
    size_t               byte_cnt;

    logic                accept;
    logic                first;
    logic                write_ok;
    logic [ADDR_WID-1:0] cur_addr;
    size_t               word_bytes;
    size_t               next_bytes;
    word_t               masked_data;

    // --------------------------------------------------
    // Credit return
    // --------------------------------------------------
    // Initial grant plus one credit per word taken and at most one per cycle
    assign owed_eff = owed + OWED_WID'(pkt_valid);
    assign send     = (owed_eff != '0);

    always_ff @(posedge clk) begin
        if (srst) begin
            owed       <= OWED_WID'(CREDITS);
            pkt_credit <= 1'b0;
        end else begin
            owed       <= owed_eff - OWED_WID'(send);
            pkt_credit <= send;
        end
    end

    // --------------------------------------------------
    // Packet capture datapath
    // --------------------------------------------------
    always_comb begin
        first      = pkt_sop && !active;
        accept     = arm && pkt_valid && (active || (first && !held));
        write_ok   = first || !full;
        cur_addr   = first ? '0 : word_idx;
        word_bytes = (pkt_eop && pkt_bytes != 2'd0) ? size_t'(pkt_bytes) : size_t'(4);
        next_bytes = (first ? '0 : byte_cnt) + (write_ok ? word_bytes : '0);
        // Zero the unused tail of the last word
        case (word_bytes)
            size_t'(1): masked_data = {pkt_data[31:24], 24'h0};
            size_t'(2): masked_data = {pkt_data[31:16], 16'h0};
            size_t'(3): masked_data = {pkt_data[31:8], 8'h0};
            default:    masked_data = pkt_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            active   <= 1'b0;
            held     <= 1'b0;
            full     <= 1'b0;
            overflow <= 1'b0;
            wr_en    <= 1'b0;
            pkt_done <= 1'b0;
        end else begin
            wr_en    <= 1'b0;
            pkt_done <= 1'b0;
            if (!arm) begin
                active <= 1'b0;
                held   <= 1'b0;
            end else if (accept) begin
                if (write_ok) begin
                    wr_en    <= 1'b1;
                    word_idx <= cur_addr + 1'b1;
                    full     <= (cur_addr == ADDR_WID'(MEM_DEPTH - 1));
                end
                overflow <= !write_ok || (overflow && !first);
                byte_cnt <= next_bytes;
                if (pkt_eop) begin
                    pkt_done     <= 1'b1;
                    pkt_size     <= next_bytes;
                    pkt_meta_out <= pkt_meta;
                    pkt_overflow <= !write_ok || (overflow && !first);
                    active       <= 1'b0;
                    held         <= 1'b1;
                end else begin
                    active <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && write_ok) begin
            wr_addr <= cur_addr;
            wr_data <= masked_data;
        end
    end

endmodule

// ==== source/packet_ram.sv ====
// Capture RAM with clearing sweep
`timescale 1ns/1ns

module packet_ram import packet_capture_pkg::*; #(
    parameter int MEM_DEPTH = 64,
    localparam int ADDR_WID = $clog2(MEM_DEPTH)
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                wr_en,
    input  logic [ADDR_WID-1:0] wr_addr,
    input  word_t               wr_data,
    input  logic                rd_en,
    input  logic [ADDR_WID-1:0] rd_addr,
    output word_t               rd_data,
    output logic                init_done
);

    word_t               mem [MEM_DEPTH];
    logic [ADDR_WID-1:0] init_addr;

    // Zero sweep of one word per cycle after reset
    always_ff @(posedge clk) begin
        if (srst) begin
            init_addr <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_addr <= init_addr + 1'b1;
            if (init_addr == ADDR_WID'(MEM_DEPTH - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // Sweep owns the write port until init_done
    always_ff @(posedge clk) begin
        if (!srst && !init_done) begin
            mem[init_addr] <= '0;
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== source/packet_capture_pkg.sv ====
// Packet capture shared definitions
package packet_capture_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int WORD_WID     = 32;
    localparam int REG_ADDR_WID = 12;
    localparam int META_WID     = 16;
    localparam int SIZE_WID     = 16;

    typedef logic [WORD_WID-1:0]     word_t;
    typedef logic [REG_ADDR_WID-1:0] reg_addr_t;
    typedef logic [META_WID-1:0]     meta_t;
    typedef logic [SIZE_WID-1:0]     size_t;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    localparam reg_addr_t REG_CONTROL = 12'h000;
    localparam reg_addr_t REG_COMMAND = 12'h004;
    localparam reg_addr_t REG_STATUS  = 12'h008;
    localparam reg_addr_t REG_INFO    = 12'h00C;
    localparam reg_addr_t REG_META    = 12'h010;
    localparam reg_addr_t DATA_BASE   = 12'h800;

    // Status code field
    typedef logic [1:0] status_code_t;
    localparam status_code_t STATUS_CODE_RESET    = 2'd0;
    localparam status_code_t STATUS_CODE_DISABLED = 2'd1;
    localparam status_code_t STATUS_CODE_READY    = 2'd2;
    localparam status_code_t STATUS_CODE_BUSY     = 2'd3;

    // Command code field
    typedef logic command_code_t;
    localparam command_code_t COMMAND_CODE_NOP     = 1'b0;
    localparam command_code_t COMMAND_CODE_CAPTURE = 1'b1;

    // Capture sequencer states
    typedef enum logic [2:0] {
        RESET    = 3'd0,
        DISABLED = 3'd1,
        READY    = 3'd2,
        CAPTURE  = 3'd3,
        DONE     = 3'd4,
        ERROR    = 3'd5
    } capture_state_t;

endpackage
